// File: Makefile
TOP = tb_controlUnit

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: files.f
+incdir+include
logic/ctrlPkg.sv
logic/controlSequencer.sv
logic/controlOutputDecoder.sv
logic/aluDecoder.sv
logic/controlUnit.sv
testbench/controlUnit_asserts.sv
testbench/tb_controlUnit.sv

// File: include/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// Instruction opcodes
`define OP_LW       6'h23
`define OP_SW       6'h2B
`define OP_RTYPE    6'h00
`define OP_POUT     6'h31   // Memory to UART transmit
`define OP_ADDI     6'h08
`define OP_ANDI     6'h0C

// R-type funct field values
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLL      6'h00

// ALU control codes seen by the datapath ALU
`define ALU_ADD     3'd2
`define ALU_SUB     3'd6
`define ALU_AND     3'd0
`define ALU_OR      3'd1
`define ALU_SLL     3'd7

`endif

// File: logic/aluDecoder.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module aluDecoder
(
    input  ctrlPkg::aluOp_t     aluOp_i,
    input  ctrlPkg::funct_t     funct_i,
    output ctrlPkg::aluCtrl_t   aluControl_o
);
    import ctrlPkg::*;

    aluCtrl_t functCode;    // R-type operation from funct

    always_comb
    begin
        case (funct_i)
            `FN_ADD:  functCode = `ALU_ADD;
            `FN_SUB:  functCode = `ALU_SUB;
            `FN_AND:  functCode = `ALU_AND;
            `FN_OR:   functCode = `ALU_OR;
            `FN_SLL:  functCode = `ALU_SLL;
            default:  functCode = `ALU_ADD;     // Unlisted funct falls back to add
        endcase
    end

    // Class picks a fixed op or defers to funct
    always_comb
    begin
        case (aluOp_i)
            2'd0:
                aluControl_o = `ALU_ADD;
            2'd1:
                aluControl_o = `ALU_SUB;
            default:
                aluControl_o = functCode;
        endcase
    end

endmodule

// File: logic/controlOutputDecoder.sv
`timescale 1ns/1ps

module controlOutputDecoder
(
    input  ctrlPkg::ctrlState_t state_i,
    // Mux selects
    output logic                sendTx_o,
    output logic                memToReg_o,
    output logic                regDst_o,
    output logic                iorD_o,
    output logic                aluSrcA_o,
    output ctrlPkg::aluSrcB_t   aluSrcB_o,
    // Write enables
    output logic                irWrite_o,
    output logic                memWrite_o,
    output logic                pcWrite_o,
    output logic                regWrite_o,
    output logic                txRegWrite_o,
    output ctrlPkg::aluOp_t     aluOp_o
);
    import ctrlPkg::*;

    always_comb
    begin
        // Everything inactive unless the state asks for it
        sendTx_o     = 1'b0;
        memToReg_o   = 1'b0;
        regDst_o     = 1'b0;
        iorD_o       = 1'b0;
        aluSrcA_o    = 1'b0;
        aluSrcB_o    = 2'd0;
        irWrite_o    = 1'b0;
        memWrite_o   = 1'b0;
        pcWrite_o    = 1'b0;
        regWrite_o   = 1'b0;
        txRegWrite_o = 1'b0;
        aluOp_o      = 2'd0;

        case (state_i)
            Fetch:
            begin
                irWrite_o = 1'b1;
                pcWrite_o = 1'b1;
                aluSrcB_o = 2'd1;       // PC + 4
            end
            Decode:
            begin
                pcWrite_o = 1'b1;
                aluSrcB_o = 2'd1;
            end
            MemAddr, AddiExecute, PoutMemAddr:
            begin
                aluSrcA_o = 1'b1;       // Base register
                aluSrcB_o = 2'd2;       // Sign-extended offset
            end
            MemRead:
                iorD_o = 1'b1;
            MemWriteBack:
            begin
                memToReg_o = 1'b1;
                regWrite_o = 1'b1;
            end
            MemWrite:
            begin
                iorD_o     = 1'b1;
                memWrite_o = 1'b1;
            end
            Execute:
            begin
                aluSrcA_o = 1'b1;
                aluOp_o   = 2'd2;       // Funct decides
            end
            AluWriteBack:
            begin
                regDst_o   = 1'b1;      // rd destination
                regWrite_o = 1'b1;
            end
            AndiExecute:
            begin
                aluSrcA_o = 1'b1;
                aluSrcB_o = 2'd3;       // Zero-extended imm
                // Class 1, so the ALU gets the subtract code here
                aluOp_o   = 2'd1;
            end
            AddiWriteBack, AndiWriteBack:
                regWrite_o = 1'b1;
            PoutMemRead:
            begin
                iorD_o       = 1'b1;
                txRegWrite_o = 1'b1;    // Capture byte for UART
            end
            PoutWriteBack:
            begin
                memToReg_o = 1'b1;
                regWrite_o = 1'b1;
                sendTx_o   = 1'b1;      // Single-cycle transmit request
            end
            default:
                aluOp_o = 2'd0;
        endcase
    end

endmodule

// File: logic/controlSequencer.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module controlSequencer
(
    input  logic                rst_i,      // Clock
    input  logic                clk_i,      // Async reset, active high
    input  ctrlPkg::opcode_t    opCode_i,
    input  logic                uartDone_i,
    output ctrlPkg::ctrlState_t state_o
);
    import ctrlPkg::*;

    ctrlState_t stateQ;
    ctrlState_t stateD;

    always_ff @(posedge rst_i or posedge clk_i)
    begin
        if (clk_i)
            stateQ <= Fetch;
        else
            stateQ <= stateD;
    end

    always_comb
    begin
        stateD = Fetch;     // Every path ends back here
        case (stateQ)
            Fetch:
                stateD = Decode;
            Decode:
            begin
                case (opCode_i)
                    `OP_LW, `OP_SW, `OP_POUT:
                        stateD = MemAddr;
                    `OP_RTYPE:
                        stateD = Execute;
                    `OP_ADDI:
                        stateD = AddiExecute;
                    `OP_ANDI:
                        stateD = AndiExecute;
                    default:
                        stateD = Fetch;     // Unknown opcode, skip it
                endcase
            end
            MemAddr:
            begin
                if (opCode_i == `OP_LW)
                    stateD = MemRead;
                else if (opCode_i == `OP_SW)
                    stateD = MemWrite;
                else if (opCode_i == `OP_POUT)
                    stateD = uartDone_i ? MemWrite : MemAddr;   // Wait for UART idle
            end
            MemRead:
                stateD = MemWriteBack;
            MemWrite:
                stateD = (opCode_i == `OP_POUT) ? PoutMemAddr : Fetch;
            Execute:
                stateD = AluWriteBack;
            AddiExecute:
                stateD = AddiWriteBack;
            AndiExecute:
                stateD = AndiWriteBack;
            PoutMemAddr:
                stateD = PoutMemRead;
            PoutMemRead:
                stateD = PoutWriteBack;
            MemWriteBack, AluWriteBack, AddiWriteBack, AndiWriteBack, PoutWriteBack:
                stateD = Fetch;
            default:
                stateD = Fetch;     // Unused encoding
        endcase
    end

    assign state_o = stateQ;

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
(
    input  logic                rst_i,      // Clock
    input  logic                clk_i,      // Async reset, active high
    input  logic                uartDone_i,
    input  ctrlPkg::opcode_t    opCode_i,
    input  ctrlPkg::funct_t     funct_i,
    output logic                sendTx_o,
    output logic                memToReg_o,
    output logic                regDst_o,
    output logic                iorD_o,
    output logic                aluSrcA_o,
    output ctrlPkg::aluSrcB_t   aluSrcB_o,
    output logic                irWrite_o,
    output logic                memWrite_o,
    output logic                pcWrite_o,
    output logic                regWrite_o,
    output logic                txRegWrite_o,
    output ctrlPkg::aluCtrl_t   aluControl_o
);
    import ctrlPkg::*;

    ctrlState_t state;
    aluOp_t     aluOp;

    controlSequencer seq0
    (
        .rst_i      (rst_i),
        .clk_i      (clk_i),
        .opCode_i   (opCode_i),
        .uartDone_i (uartDone_i),
        .state_o    (state)
    );

    // Moore outputs straight from the state
    controlOutputDecoder outDec0
    (
        .state_i      (state),
        .sendTx_o     (sendTx_o),
        .memToReg_o   (memToReg_o),
        .regDst_o     (regDst_o),
        .iorD_o       (iorD_o),
        .aluSrcA_o    (aluSrcA_o),
        .aluSrcB_o    (aluSrcB_o),
        .irWrite_o    (irWrite_o),
        .memWrite_o   (memWrite_o),
        .pcWrite_o    (pcWrite_o),
        .regWrite_o   (regWrite_o),
        .txRegWrite_o (txRegWrite_o),
        .aluOp_o      (aluOp)
    );

    aluDecoder aluDec0
    (
        .aluOp_i      (aluOp),
        .funct_i      (funct_i),
        .aluControl_o (aluControl_o)
    );

endmodule

// File: logic/ctrlPkg.sv
package ctrlPkg;

    typedef logic [5:0] opcode_t;   // Instruction bits 31:26
    typedef logic [5:0] funct_t;    // Instruction bits 5:0
    typedef logic [2:0] aluCtrl_t;
    typedef logic [1:0] aluOp_t;    // 0 add, 1 subtract, 2 from funct

    // ALU B operand: 0 register, 1 constant four, 2 sign-ext imm, 3 zero-ext imm
    typedef logic [1:0] aluSrcB_t;

    // Multicycle sequence, one state per datapath step
    typedef enum logic [3:0]
    {
        Fetch,
        Decode,
        MemAddr,
        MemRead,
        MemWriteBack,
        MemWrite,
        Execute,
        AluWriteBack,
        AddiExecute,
        AddiWriteBack,
        AndiExecute,
        AndiWriteBack,
        PoutMemAddr,
        PoutMemRead,
        PoutWriteBack
    } ctrlState_t;

endpackage

// File: testbench/controlUnit_asserts.sv
`timescale 1ns/1ps

module controlUnit_asserts
(
    input logic rst_i,      // Clock
    input logic clk_i,      // Async reset, active high
    input logic memWrite_i,
    input logic regWrite_i,
    input logic txRegWrite_i,
    input logic sendTx_i,
    input logic irWrite_i,
    input logic pcWrite_i
);

    // Memory and register file never written together
    noWriteClash: assert property (@(posedge rst_i) disable iff (clk_i)
        !(memWrite_i && regWrite_i))
        else $error("memWrite and regWrite high in the same cycle");

    txThenSend: assert property (@(posedge rst_i) disable iff (clk_i)
        txRegWrite_i |=> sendTx_i)
        else $error("sendTx did not follow txRegWrite");

    // Transmit request is a single-cycle strobe
    sendOnce: assert property (@(posedge rst_i) disable iff (clk_i)
        sendTx_i |=> !sendTx_i)
        else $error("sendTx held longer than one cycle");

    irImpliesPc: assert property (@(posedge rst_i) disable iff (clk_i)
        irWrite_i |-> pcWrite_i)
        else $error("irWrite high without pcWrite");

endmodule

// File: testbench/tb_controlUnit.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module tb_controlUnit;
    import ctrlPkg::*;

    localparam int NumInstr   = 14;
    localparam int CycleLimit = 20 * NumInstr + 50;

    logic rst;      // Clock
    logic clk;      // Async reset, active high
    logic uartDone;
    opcode_t opCode;
    funct_t funct;
    logic sendTx, memToReg, regDst, iorD, aluSrcA, irWrite;
    logic memWrite, pcWrite, regWrite, txRegWrite;
    aluSrcB_t aluSrcB;
    aluCtrl_t aluControl;
    logic [14:0] dutWord;
    ctrlState_t modelState;
    int errors = 0;
    int cycleCount = 0;
    int doneWaits = 0;      // MemAddr edges spent waiting on the UART
    int seed = 78;
    int randVal;

    controlUnit dut0
    (
        .rst_i(rst), .clk_i(clk), .uartDone_i(uartDone), .opCode_i(opCode), .funct_i(funct),
        .sendTx_o(sendTx), .memToReg_o(memToReg), .regDst_o(regDst), .iorD_o(iorD),
        .aluSrcA_o(aluSrcA), .aluSrcB_o(aluSrcB), .irWrite_o(irWrite), .memWrite_o(memWrite),
        .pcWrite_o(pcWrite), .regWrite_o(regWrite), .txRegWrite_o(txRegWrite),
        .aluControl_o(aluControl)
    );

    bind controlUnit controlUnit_asserts asrt0
    (
        .rst_i(rst_i), .clk_i(clk_i), .memWrite_i(memWrite_o), .regWrite_i(regWrite_o),
        .txRegWrite_i(txRegWrite_o), .sendTx_i(sendTx_o), .irWrite_i(irWrite_o),
        .pcWrite_i(pcWrite_o)
    );

    assign dutWord = {sendTx, memToReg, regDst, iorD, aluSrcA, aluSrcB, irWrite, memWrite,
                      pcWrite, regWrite, txRegWrite, aluControl};

    function automatic ctrlState_t nextState(input ctrlState_t st, input opcode_t op,
                                             input logic done);
        ctrlState_t nxt;
        nxt = Fetch;
        case (st)
            Fetch:        nxt = Decode;
            Decode:
            begin
                if (op == `OP_LW || op == `OP_SW || op == `OP_POUT)
                    nxt = MemAddr;
                else if (op == `OP_RTYPE)
                    nxt = Execute;
                else if (op == `OP_ADDI)
                    nxt = AddiExecute;
                else if (op == `OP_ANDI)
                    nxt = AndiExecute;
            end
            MemAddr:
            begin
                if (op == `OP_LW)
                    nxt = MemRead;
                else if (op == `OP_SW || (op == `OP_POUT && done))
                    nxt = MemWrite;
                else if (op == `OP_POUT)
                    nxt = MemAddr;
            end
            MemRead:      nxt = MemWriteBack;
            MemWrite:     nxt = (op == `OP_POUT) ? PoutMemAddr : Fetch;
            Execute:      nxt = AluWriteBack;
            AddiExecute:  nxt = AddiWriteBack;
            AndiExecute:  nxt = AndiWriteBack;
            PoutMemAddr:  nxt = PoutMemRead;
            PoutMemRead:  nxt = PoutWriteBack;
            default:      nxt = Fetch;
        endcase
        return nxt;
    endfunction

    // Expected control word for one state, from the per-state output table
    function automatic logic [14:0] expectWord(input ctrlState_t st, input funct_t fn);
        logic [11:0] flags;
        aluOp_t cls;
        aluCtrl_t fnCode;
        aluCtrl_t ac;
        cls = 2'd0;
        // sendTx memToReg regDst iorD aluSrcA aluSrcB irWrite memWrite pcWrite regWrite txRegWrite
        case (st)
            Fetch:                     flags = 12'b0_0_0_0_0_01_1_0_1_0_0;
            Decode:                    flags = 12'b0_0_0_0_0_01_0_0_1_0_0;
            MemAddr, PoutMemAddr:      flags = 12'b0_0_0_0_1_10_0_0_0_0_0;
            AddiExecute:               flags = 12'b0_0_0_0_1_10_0_0_0_0_0;
            MemRead:                   flags = 12'b0_0_0_1_0_00_0_0_0_0_0;
            MemWriteBack:              flags = 12'b0_1_0_0_0_00_0_0_0_1_0;
            MemWrite:                  flags = 12'b0_0_0_1_0_00_0_1_0_0_0;
            AluWriteBack:              flags = 12'b0_0_1_0_0_00_0_0_0_1_0;
            AddiWriteBack, AndiWriteBack: flags = 12'b0_0_0_0_0_00_0_0_0_1_0;
            PoutMemRead:               flags = 12'b0_0_0_1_0_00_0_0_0_0_1;
            PoutWriteBack:             flags = 12'b1_1_0_0_0_00_0_0_0_1_0;
            Execute:
            begin
                flags = 12'b0_0_0_0_1_00_0_0_0_0_0;
                cls   = 2'd2;
            end
            AndiExecute:
            begin
                flags = 12'b0_0_0_0_1_11_0_0_0_0_0;
                cls   = 2'd1;       // Subtract class kept for ANDI
            end
            default:                   flags = 12'b0;
        endcase
        case (fn)
            `FN_ADD: fnCode = `ALU_ADD;
            `FN_SUB: fnCode = `ALU_SUB;
            `FN_AND: fnCode = `ALU_AND;
            `FN_OR:  fnCode = `ALU_OR;
            `FN_SLL: fnCode = `ALU_SLL;
            default: fnCode = `ALU_ADD;
        endcase
        ac = (cls == 2'd0) ? `ALU_ADD : (cls == 2'd1) ? `ALU_SUB : fnCode;
        return {flags, ac};
    endfunction

    task automatic checkField(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h expected %h (state %s)", name, got, exp, modelState.name());
        end
    endtask

    task automatic runInstr(input opcode_t op, input funct_t fn, input int baseCycles);
        int cycles;
        int waitsAtStart;
        int expCycles;
        opCode = op;
        funct = fn;
        waitsAtStart = doneWaits;
        cycles = 0;
        do
        begin
            @(posedge rst);
            #1;
            cycles++;
        end
        while (irWrite !== 1'b1);
        expCycles = baseCycles + doneWaits - waitsAtStart;
        if (cycles != expCycles)
        begin
            errors++;
            $display("Fail cycles for opcode %h: got %h expected %h", op, cycles, expCycles);
        end
    endtask

    always #20 rst = ~rst;

    // Reference next-state model
    always @(posedge rst or posedge clk)
    begin
        if (clk)
            modelState <= Fetch;
        else
        begin
            if (modelState == MemAddr && opCode == `OP_POUT && !uartDone)
                doneWaits <= doneWaits + 1;
            modelState <= nextState(modelState, opCode, uartDone);
        end
    end

    // Compare every cycle at the falling edge
    always @(negedge rst)
    begin
        logic [14:0] exp;
        exp = expectWord(modelState, funct);
        if (!clk)
        begin
            checkField("sendTx_o", 3'(dutWord[14]), 3'(exp[14]));
            checkField("memToReg_o", 3'(dutWord[13]), 3'(exp[13]));
            checkField("regDst_o", 3'(dutWord[12]), 3'(exp[12]));
            checkField("iorD_o", 3'(dutWord[11]), 3'(exp[11]));
            checkField("aluSrcA_o", 3'(dutWord[10]), 3'(exp[10]));
            checkField("aluSrcB_o", 3'(dutWord[9:8]), 3'(exp[9:8]));
            checkField("irWrite_o", 3'(dutWord[7]), 3'(exp[7]));
            checkField("memWrite_o", 3'(dutWord[6]), 3'(exp[6]));
            checkField("pcWrite_o", 3'(dutWord[5]), 3'(exp[5]));
            checkField("regWrite_o", 3'(dutWord[4]), 3'(exp[4]));
            checkField("txRegWrite_o", 3'(dutWord[3]), 3'(exp[3]));
            checkField("aluControl_o", dutWord[2:0], exp[2:0]);
        end
    end

    always @(posedge rst)
    begin
        #1;
        randVal = $random(seed);
        uartDone = randVal[0];
    end

    always @(posedge rst)
    begin
        cycleCount++;
        if (cycleCount > CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        rst = 1'b0;
        clk = 1'b1;
        uartDone = 1'b0;
        opCode = `OP_RTYPE;
        funct = `FN_ADD;
        repeat (4) @(posedge rst);
        #1;
        clk = 1'b0;
        #1;
        if (dutWord !== expectWord(Fetch, funct))
        begin
            errors++;
            $display("Fail outputs after reset: got %h expected %h", dutWord,
                     expectWord(Fetch, funct));
        end
        runInstr(`OP_LW, `FN_ADD, 5);
        runInstr(`OP_SW, `FN_ADD, 4);
        runInstr(`OP_ADDI, `FN_ADD, 4);
        runInstr(`OP_RTYPE, `FN_ADD, 4);
        runInstr(`OP_RTYPE, `FN_SUB, 4);
        runInstr(`OP_RTYPE, `FN_AND, 4);
        runInstr(`OP_RTYPE, `FN_OR, 4);
        runInstr(`OP_RTYPE, `FN_SLL, 4);
        runInstr(`OP_RTYPE, 6'h3F, 4);      // Unlisted funct
        runInstr(`OP_ANDI, `FN_ADD, 4);
        repeat (3) runInstr(`OP_POUT, `FN_ADD, 7);
        runInstr(6'h3E, `FN_ADD, 2);        // Unknown opcode
        $display("Error count: %0d", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
